// ==== project.f ====
design/multipu_pkg.sv
design/pu_wake.sv
design/pu.sv
design/pi1q.sv
design/multipu.sv
verif/pi1_mem_model.sv
verif/tb_multipu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module tb_multipu -o tb_multipu
	./obj_dir/tb_multipu | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_multipu.sv ====
////////////////////
// multipu cluster testbench
// directed tests for boot, wake, contention,
// bus ordering and reset in the middle of a run
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_multipu;

	// 4 units times about 40 accesses times up to 5 cycles an access times 5 tests
	localparam int MAX_CYCLES = 4000;
	localparam logic [multipu_pkg::XADDRBITSZ-1:0] BOOT0_ADDR = 15'h1000;
	localparam logic [multipu_pkg::XADDRBITSZ-1:0] RES0_ADDR  = 15'h1800;
	localparam logic [multipu_pkg::XADDRBITSZ-1:0] WAKE_A     = 15'h2000;
	localparam logic [multipu_pkg::XADDRBITSZ-1:0] WAKE_B     = 15'h3000;
	localparam logic [multipu_pkg::ARCHBITSZ-1:0]  ID_BASE    = 16'h0030;
	localparam logic [multipu_pkg::ARCHBITSZ-1:0]  OPND_A     = 16'h1234;
	localparam logic [multipu_pkg::ARCHBITSZ-1:0]  OPND_B     = 16'h0abc;

	logic                                 clk;
	logic                                 rst_n;
	logic [multipu_pkg::PUCOUNT-1:0]      intrqst;
	logic [multipu_pkg::PUCOUNT-1:0]      intrdy;
	logic [multipu_pkg::PUCOUNT-1:0]      halted;
	logic [multipu_pkg::XADDRBITSZ-1:0]   rstaddr;
	logic [multipu_pkg::XADDRBITSZ-1:0]   rstaddr2;
	logic [multipu_pkg::ARCHBITSZ-1:0]    id;
	logic [1:0]                           pi1_op;
	logic [multipu_pkg::XADDRBITSZ-1:0]   pi1_addr;
	logic [multipu_pkg::ARCHBITSZ-1:0]    pi1_wdata;
	logic [multipu_pkg::ARCHBITSZ-1:0]    pi1_rdata;
	logic [multipu_pkg::SELBITSZ-1:0]     pi1_sel;
	logic                                 pi1_rdy;
	logic                                 bd_we;
	logic [multipu_pkg::XADDRBITSZ-1:0]   bd_addr;
	logic [multipu_pkg::ARCHBITSZ-1:0]    bd_data;
	logic                                 hold_err;

	// preloaded words by address
	logic [multipu_pkg::ARCHBITSZ-1:0]    shadow [int];
	int                                   rd_cnt = 0;
	int                                   wr_cnt = 0;
	int                                   cycle_cnt = 0;

	multipu i_multipu (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.pi1_op_o   (pi1_op),
		.pi1_addr_o (pi1_addr),
		.pi1_data_o (pi1_wdata),
		.pi1_data_i (pi1_rdata),
		.pi1_sel_o  (pi1_sel),
		.pi1_rdy_i  (pi1_rdy),
		.intrqst_i  (intrqst),
		.intrdy_o   (intrdy),
		.halted_o   (halted),
		.rstaddr_i  (rstaddr),
		.rstaddr2_i (rstaddr2),
		.id_i       (id)
	);

	pi1_mem_model i_pi1_mem_model (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.op_i       (pi1_op),
		.addr_i     (pi1_addr),
		.data_i     (pi1_wdata),
		.sel_i      (pi1_sel),
		.data_o     (pi1_rdata),
		.rdy_o      (pi1_rdy),
		.bd_we_i    (bd_we),
		.bd_addr_i  (bd_addr),
		.bd_data_i  (bd_data),
		.hold_err_o (hold_err)
	);

	always #4 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the cluster never finished", cycle_cnt);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	// bus monitor sampled mid-cycle
	// a read must return the word that was preloaded there
	always @(negedge clk) begin
		if (rst_n) begin
			check("pi1 op hold error", hold_err, 1'b0);
			if (pi1_rdy && pi1_op == multipu_pkg::PIRDOP) begin
				rd_cnt++;
				if (!shadow.exists(pi1_addr)) begin
					$display("read from address %h that was never loaded", pi1_addr);
					$display("TEST FAIL");
					$fatal(1);
				end
				check("pi1_data_i", pi1_rdata, shadow[pi1_addr]);
			end else if (pi1_rdy && pi1_op == multipu_pkg::PIWROP) begin
				wr_cnt++;
				check("pi1_sel_o", pi1_sel, 2'b11);
			end
		end
	end

	function automatic logic [15:0] encode_instr(input multipu_pkg::pu_opcode_e op,
		input logic [11:0] arg);
		return {op, arg};
	endfunction

	// STX target is the start address window plus the offset and the unit id
	function automatic logic [14:0] stx_slot(input logic [14:0] base, input logic [11:0] off,
		input int k);
		return {base[14:12], off} + ID_BASE[14:0] + 15'(k);
	endfunction

	// all tasks start and end 1 ns after a rising edge
	task automatic mem_write(input logic [14:0] a, input logic [15:0] d);
		bd_we   = 1'b1;
		bd_addr = a;
		bd_data = d;
		@(posedge clk);
		#1;
		bd_we = 1'b0;
		shadow[a] = d;
	endtask

	task automatic apply_reset();
		rst_n   = 1'b0;
		intrqst = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic pulse_wake(input logic [3:0] mask);
		intrqst = mask;
		@(posedge clk);
		#1;
		intrqst = '0;
	endtask

	task automatic wait_halted(input logic [3:0] mask);
		while ((halted & mask) != mask) begin
			@(posedge clk);
			#1;
		end
	endtask

	// LD, ADD onto it, STX the sum, HALT
	task automatic load_sum_program();
		mem_write(WAKE_B, encode_instr(multipu_pkg::OP_LD, 12'h100));
		mem_write(WAKE_B + 15'd1, encode_instr(multipu_pkg::OP_ADD, 12'h101));
		mem_write(WAKE_B + 15'd2, encode_instr(multipu_pkg::OP_STX, 12'h200));
		mem_write(WAKE_B + 15'd3, encode_instr(multipu_pkg::OP_HALT, 12'h000));
		mem_write(WAKE_B + 15'h100, OPND_A);
		mem_write(WAKE_B + 15'h101, OPND_B);
		for (int k = 1; k < 4; k++) mem_write(stx_slot(WAKE_B, 12'h200, k), 16'h0000);
	endtask

	task automatic boot_unit0_only();
		mem_write(BOOT0_ADDR, encode_instr(multipu_pkg::OP_LDI, 12'h123));
		mem_write(BOOT0_ADDR + 15'd1, encode_instr(multipu_pkg::OP_ADDI, 12'h045));
		mem_write(BOOT0_ADDR + 15'd2, encode_instr(multipu_pkg::OP_ST, 12'h800));
		mem_write(BOOT0_ADDR + 15'd3, encode_instr(multipu_pkg::OP_HALT, 12'h000));
		mem_write(RES0_ADDR, 16'h0000);
		apply_reset();
		wait_halted(4'b0001);
		check("halted_o", halted, 4'b0001);
		check("intrdy_o", intrdy, 4'b1110);
		check("unit 0 result", i_pi1_mem_model.mem_q[RES0_ADDR], 16'h0123 + 16'h0045);
	endtask

	task automatic wake_unit2_once();
		int busy_cycles;
		busy_cycles = 0;
		rstaddr2 = WAKE_A;
		mem_write(WAKE_A, encode_instr(multipu_pkg::OP_LID, 12'h000));
		mem_write(WAKE_A + 15'd1, encode_instr(multipu_pkg::OP_STX, 12'h400));
		mem_write(WAKE_A + 15'd2, encode_instr(multipu_pkg::OP_HALT, 12'h000));
		mem_write(stx_slot(WAKE_A, 12'h400, 2), 16'h0000);
		apply_reset();
		pulse_wake(4'b0100);
		check("intrdy_o after wake", intrdy, 4'b1010);
		wait_halted(4'b0101);
		check("unit 2 id slot", i_pi1_mem_model.mem_q[stx_slot(WAKE_A, 12'h400, 2)],
			ID_BASE + 16'd2);
		// second pulse to an awake unit is dropped and the bus stays quiet
		pulse_wake(4'b0100);
		repeat (20) begin
			if (pi1_op != multipu_pkg::PINOOP) busy_cycles++;
			@(posedge clk);
			#1;
		end
		check("bus cycles after repeat wake", busy_cycles, 0);
		check("halted_o", halted, 4'b0101);
		check("intrdy_o", intrdy, 4'b1010);
	endtask

	task automatic contend_three_units();
		rstaddr2 = WAKE_B;
		load_sum_program();
		apply_reset();
		pulse_wake(4'b1110);
		check("intrdy_o after wake", intrdy, 4'b0000);
		wait_halted(4'b1111);
		for (int k = 1; k < 4; k++) begin
			check("unit result slot", i_pi1_mem_model.mem_q[stx_slot(WAKE_B, 12'h200, k)],
				OPND_A + OPND_B);
		end
	endtask

	task automatic count_bus_order();
		int rd_start;
		int wr_start;
		load_sum_program();
		rd_start = rd_cnt;
		wr_start = wr_cnt;
		apply_reset();
		pulse_wake(4'b1010);
		wait_halted(4'b1011);
		// unit 0 does 4 fetches and units 1 and 3 do 4 fetches and 2 loads each
		check("bus read count", rd_cnt - rd_start, 16);
		check("bus write count", wr_cnt - wr_start, 3);
		check("unit 1 slot", i_pi1_mem_model.mem_q[stx_slot(WAKE_B, 12'h200, 1)],
			OPND_A + OPND_B);
		check("unit 3 slot", i_pi1_mem_model.mem_q[stx_slot(WAKE_B, 12'h200, 3)],
			OPND_A + OPND_B);
	endtask

	task automatic reset_mid_run();
		apply_reset();
		pulse_wake(4'b0010);
		wait_halted(4'b0001);
		// reset cuts off unit 1 in the middle of its program
		rst_n = 1'b0;
		@(posedge clk);
		#1;
		check("halted_o in reset", halted, 4'b0000);
		check("intrdy_o in reset", intrdy, 4'b1110);
		mem_write(RES0_ADDR, 16'h0000);
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		wait_halted(4'b0001);
		check("halted_o after rerun", halted, 4'b0001);
		check("intrdy_o after rerun", intrdy, 4'b1110);
		check("unit 0 rerun result", i_pi1_mem_model.mem_q[RES0_ADDR], 16'h0123 + 16'h0045);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		intrqst  = '0;
		rstaddr  = BOOT0_ADDR;
		rstaddr2 = WAKE_A;
		id       = ID_BASE;
		bd_we    = 1'b0;
		bd_addr  = '0;
		bd_data  = '0;
		@(posedge clk);
		#1;
		boot_unit0_only();
		wake_unit2_once();
		contend_three_units();
		count_bus_order();
		reset_mid_run();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/pi1_mem_model.sv ====
////////////////////
// pi1 memory model
// halfword memory on the slave side of the pi1 bus,
// a random stall per access and an op hold monitor
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pi1_mem_model (
	input  wire                                clk_i,
	input  wire                                rst_n_i,
	input  wire  [1:0]                         op_i,
	input  wire  [multipu_pkg::XADDRBITSZ-1:0] addr_i,
	input  wire  [multipu_pkg::ARCHBITSZ-1:0]  data_i,
	input  wire  [multipu_pkg::SELBITSZ-1:0]   sel_i,
	output logic [multipu_pkg::ARCHBITSZ-1:0]  data_o,
	output logic                               rdy_o,
	input  wire                                bd_we_i,
	input  wire  [multipu_pkg::XADDRBITSZ-1:0] bd_addr_i,
	input  wire  [multipu_pkg::ARCHBITSZ-1:0]  bd_data_i,
	output logic                               hold_err_o
);

	logic [multipu_pkg::ARCHBITSZ-1:0]  mem_q [2**multipu_pkg::XADDRBITSZ];
	logic                               busy_q;
	logic [1:0]                         cnt_q;
	logic [1:0]                         op_q;
	logic [multipu_pkg::XADDRBITSZ-1:0] addr_q;
	logic [multipu_pkg::ARCHBITSZ-1:0]  wdata_q;
	logic [multipu_pkg::SELBITSZ-1:0]   sel_q;
	logic [15:0]                        lfsr_q;
	logic [15:0]                        lfsr1_w;
	logic [15:0]                        lfsr2_w;
	logic                               done_w;

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// two steps, one bit taken from each
	assign lfsr1_w = lfsr_step(lfsr_q);
	assign lfsr2_w = lfsr_step(lfsr1_w);
	// stall count ran out, access completes at this edge
	assign done_w = busy_q && (cnt_q == 2'd0);

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q     <= 1'b0;
			cnt_q      <= 2'd0;
			rdy_o      <= 1'b0;
			data_o     <= '0;
			hold_err_o <= 1'b0;
			lfsr_q     <= 16'd4;
			op_q       <= multipu_pkg::PINOOP;
			addr_q     <= '0;
			wdata_q    <= '0;
			sel_q      <= '0;
		end else begin
			rdy_o <= 1'b0;
			// op and address must stay put until the rdy cycle is over
			if ((busy_q || rdy_o) && (op_i != op_q || addr_i != addr_q)) begin
				hold_err_o <= 1'b1;
			end
			if (done_w) begin
				busy_q <= 1'b0;
				rdy_o  <= 1'b1;
				data_o <= mem_q[addr_q];
			end else if (busy_q) begin
				cnt_q <= cnt_q - 2'd1;
			end else if (!rdy_o && op_i != multipu_pkg::PINOOP) begin
				// new access, 0 to 3 stall cycles
				busy_q  <= 1'b1;
				op_q    <= op_i;
				addr_q  <= addr_i;
				wdata_q <= data_i;
				sel_q   <= sel_i;
				cnt_q   <= {lfsr2_w[0], lfsr1_w[0]};
				lfsr_q  <= lfsr2_w;
			end
		end
	end

	// backdoor preload wins over a bus write
	always @(posedge clk_i) begin
		if (bd_we_i) begin
			mem_q[bd_addr_i] <= bd_data_i;
		end else if (done_w && op_q == multipu_pkg::PIWROP) begin
			if (sel_q[0]) mem_q[addr_q][7:0] <= wdata_q[7:0];
			if (sel_q[1]) mem_q[addr_q][15:8] <= wdata_q[15:8];
		end
	end

endmodule

`default_nettype wire

// ==== design/multipu.sv ====
////////////////////
// multipu cluster top
// wake controller, PUCOUNT units and the pi1 arbiter
// sharing one pi1 bus on a single clock
////////////////////
`timescale 1ns/1ps
`default_nettype none

module multipu (
	input  wire                                clk_i,
	input  wire                                rst_n_i,
	output wire [1:0]                          pi1_op_o,
	output wire [multipu_pkg::XADDRBITSZ-1:0]  pi1_addr_o,
	output wire [multipu_pkg::ARCHBITSZ-1:0]   pi1_data_o,
	input  wire [multipu_pkg::ARCHBITSZ-1:0]   pi1_data_i,
	output wire [multipu_pkg::SELBITSZ-1:0]    pi1_sel_o,
	input  wire                                pi1_rdy_i,
	input  wire [multipu_pkg::PUCOUNT-1:0]     intrqst_i,
	output wire [multipu_pkg::PUCOUNT-1:0]     intrdy_o,
	output wire [multipu_pkg::PUCOUNT-1:0]     halted_o,
	input  wire [multipu_pkg::XADDRBITSZ-1:0]  rstaddr_i,
	input  wire [multipu_pkg::XADDRBITSZ-1:0]  rstaddr2_i,
	input  wire [multipu_pkg::ARCHBITSZ-1:0]   id_i
);

	// per unit boot info and bus request
	wire multipu_pkg::pu_boot_s           boot_w [multipu_pkg::PUCOUNT];
	wire multipu_pkg::pi1_req_s           req_w  [multipu_pkg::PUCOUNT];
	// shared read data and per unit rdy
	wire [multipu_pkg::ARCHBITSZ-1:0]     rdata_w;
	wire [multipu_pkg::PUCOUNT-1:0]       rdy_w;

	pu_wake i_pu_wake (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.intrqst_i  (intrqst_i),
		.rstaddr_i  (rstaddr_i),
		.rstaddr2_i (rstaddr2_i),
		.id_i       (id_i),
		.boot_o     (boot_w),
		.intrdy_o   (intrdy_o)
	);

	for (genvar genpu_idx = 0; genpu_idx < multipu_pkg::PUCOUNT; genpu_idx++) begin : genpu
		pu i_pu (
			.clk_i    (clk_i),
			.rst_n_i  (rst_n_i),
			.boot_i   (boot_w[genpu_idx]),
			.req_o    (req_w[genpu_idx]),
			.rdata_i  (rdata_w),
			.rdy_i    (rdy_w[genpu_idx]),
			.halted_o (halted_o[genpu_idx])
		);
	end

	pi1q i_pi1q (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.m_req_i    (req_w),
		.m_rdata_o  (rdata_w),
		.m_rdy_o    (rdy_w),
		.pi1_op_o   (pi1_op_o),
		.pi1_addr_o (pi1_addr_o),
		.pi1_data_o (pi1_data_o),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_o  (pi1_sel_o),
		.pi1_rdy_i  (pi1_rdy_i)
	);

endmodule

`default_nettype wire

// ==== design/pi1q.sv ====
////////////////////
// pi1 round-robin arbiter
// drains PUCOUNT pi1 masters onto one slave port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pi1q (
	input  wire                                   clk_i,
	input  wire                                   rst_n_i,
	input  wire  multipu_pkg::pi1_req_s           m_req_i [multipu_pkg::PUCOUNT],
	output logic [multipu_pkg::ARCHBITSZ-1:0]     m_rdata_o,
	output logic [multipu_pkg::PUCOUNT-1:0]       m_rdy_o,
	output logic [1:0]                            pi1_op_o,
	output logic [multipu_pkg::XADDRBITSZ-1:0]    pi1_addr_o,
	output logic [multipu_pkg::ARCHBITSZ-1:0]     pi1_data_o,
	input  wire  [multipu_pkg::ARCHBITSZ-1:0]     pi1_data_i,
	output logic [multipu_pkg::SELBITSZ-1:0]      pi1_sel_o,
	input  wire                                   pi1_rdy_i
);

	// granted master, bus busy flag, next search start
	logic [multipu_pkg::PUIDXBITSZ-1:0] gnt_q;
	logic                               busy_q;
	logic [multipu_pkg::PUIDXBITSZ-1:0] rr_q;

	logic [multipu_pkg::PUIDXBITSZ-1:0] pick_w;
	logic                               found_w;

	// first requester at or after the pointer
	always_comb begin
		logic [multipu_pkg::PUIDXBITSZ-1:0] idx;
		pick_w  = rr_q;
		found_w = 1'b0;
		for (int n = 0; n < multipu_pkg::PUCOUNT; n++) begin
			// index wraps since PUCOUNT is a power of two
			idx = rr_q + n[multipu_pkg::PUIDXBITSZ-1:0];
			if (!found_w && m_req_i[idx].op != multipu_pkg::PINOOP) begin
				found_w = 1'b1;
				pick_w  = idx;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt_q  <= '0;
			busy_q <= 1'b0;
			rr_q   <= '0;
		end else if (busy_q) begin
			// memory stalls just hold the grant
			if (pi1_rdy_i) begin
				busy_q <= 1'b0;
				rr_q   <= gnt_q + 1'b1;
			end
		end else if (found_w) begin
			gnt_q  <= pick_w;
			busy_q <= 1'b1;
		end
	end

	// granted request onto the bus, op only while busy
	assign pi1_op_o   = busy_q ? m_req_i[gnt_q].op : multipu_pkg::PINOOP;
	assign pi1_addr_o = m_req_i[gnt_q].addr;
	assign pi1_data_o = m_req_i[gnt_q].data;
	assign pi1_sel_o  = m_req_i[gnt_q].sel;

	// read data goes to everyone, rdy only to the owner
	assign m_rdata_o = pi1_data_i;

	always_comb begin
		m_rdy_o        = '0;
		m_rdy_o[gnt_q] = busy_q & pi1_rdy_i;
	end

endmodule

`default_nettype wire

// ==== design/pu.sv ====
////////////////////
// accumulator processing unit
// fetches and executes a small 16-bit ISA
// over its own pi1 master port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pu (
	input  wire                                clk_i,
	input  wire                                rst_n_i,
	input  wire  multipu_pkg::pu_boot_s        boot_i,
	output multipu_pkg::pi1_req_s              req_o,
	input  wire  [multipu_pkg::ARCHBITSZ-1:0]  rdata_i,
	input  wire                                rdy_i,
	output logic                               halted_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DATA,
		ST_EXEC
	} pu_state_e;

	pu_state_e                           state_q;
	logic                                halted_q;
	logic [1:0]                          req_op_q;
	logic [multipu_pkg::XADDRBITSZ-1:0]  req_addr_q;
	logic [multipu_pkg::ARCHBITSZ-1:0]   req_data_q;
	logic [multipu_pkg::XADDRBITSZ-1:0]  pc_q;
	logic [multipu_pkg::ARCHBITSZ-1:0]   acc_q;
	logic [multipu_pkg::ARCHBITSZ-1:0]   md_q;
	multipu_pkg::pu_instr_u              ir_q;

	multipu_pkg::pu_instr_u              fetch_w;
	logic                                mem_w;
	logic                                st_w;
	logic [multipu_pkg::XADDRBITSZ-1:0]  daddr_w;
	logic [multipu_pkg::ARCHBITSZ-1:0]   imm_w;
	logic [multipu_pkg::ARCHBITSZ-1:0]   id_w;

	// word on the bus seen as an instruction during fetch
	assign fetch_w = rdata_i;
	// these opcodes need a data transaction after the fetch
	assign mem_w = fetch_w.i.op inside {multipu_pkg::OP_LD, multipu_pkg::OP_ADD,
		multipu_pkg::OP_ST, multipu_pkg::OP_STX};
	assign st_w = ir_q.i.op inside {multipu_pkg::OP_ST, multipu_pkg::OP_STX};

	// 4K-halfword data window, upper bits from the start address
	assign daddr_w = {boot_i.startaddr[multipu_pkg::XADDRBITSZ-1:multipu_pkg::IMMBITSZ],
		ir_q.m.addr};
	assign imm_w = {{(multipu_pkg::ARCHBITSZ-multipu_pkg::IMMBITSZ){1'b0}}, ir_q.i.imm};
	assign id_w = {{(multipu_pkg::ARCHBITSZ-multipu_pkg::XADDRBITSZ){1'b0}}, boot_i.id};

	// both byte lanes on every access
	assign req_o = '{op: req_op_q, addr: req_addr_q, data: req_data_q, sel: '1};
	assign halted_o = halted_q;

	// sequencing and bus op
	// op always returns to noop for a cycle after each rdy
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= ST_IDLE;
			halted_q <= 1'b0;
			req_op_q <= multipu_pkg::PINOOP;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (boot_i.run && !halted_q) begin
						req_op_q <= multipu_pkg::PIRDOP;
						state_q  <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (rdy_i) begin
						req_op_q <= multipu_pkg::PINOOP;
						state_q  <= mem_w ? ST_DATA : ST_EXEC;
					end
				end
				ST_DATA: begin
					// first cycle is the idle gap, then issue
					if (req_op_q == multipu_pkg::PINOOP) begin
						req_op_q <= st_w ? multipu_pkg::PIWROP : multipu_pkg::PIRDOP;
					end else if (rdy_i) begin
						req_op_q <= multipu_pkg::PINOOP;
						state_q  <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					if (ir_q.i.op == multipu_pkg::OP_HALT) begin
						halted_q <= 1'b1;
						state_q  <= ST_IDLE;
					end else begin
						req_op_q <= multipu_pkg::PIRDOP;
						state_q  <= ST_FETCH;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk_i) begin
		case (state_q)
			ST_IDLE: begin
				// pc parked on the start address until run
				pc_q       <= boot_i.startaddr;
				req_addr_q <= boot_i.startaddr;
			end
			ST_FETCH: begin
				if (rdy_i) ir_q <= fetch_w;
			end
			ST_DATA: begin
				if (req_op_q == multipu_pkg::PINOOP) begin
					// STX is offset by the unit id
					req_addr_q <= (ir_q.m.op == multipu_pkg::OP_STX) ? daddr_w + boot_i.id : daddr_w;
					req_data_q <= acc_q;
				end else if (rdy_i) begin
					md_q <= rdata_i;
				end
			end
			ST_EXEC: begin
				case (ir_q.i.op)
					multipu_pkg::OP_LDI:  acc_q <= imm_w;
					multipu_pkg::OP_LID:  acc_q <= id_w;
					multipu_pkg::OP_LD:   acc_q <= md_q;
					multipu_pkg::OP_ADD:  acc_q <= acc_q + md_q;
					multipu_pkg::OP_ADDI: acc_q <= acc_q + imm_w;
					default: ;
				endcase
				// next fetch address
				pc_q       <= pc_q + 1'b1;
				req_addr_q <= pc_q + 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/pu_wake.sv ====
////////////////////
// wake controller
// releases unit 0 out of reset and the other units
// on intrqst pulses, with start address and id per unit
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pu_wake (
	input  wire                                      clk_i,
	input  wire                                      rst_n_i,
	input  wire  [multipu_pkg::PUCOUNT-1:0]          intrqst_i,
	input  wire  [multipu_pkg::XADDRBITSZ-1:0]       rstaddr_i,
	input  wire  [multipu_pkg::XADDRBITSZ-1:0]       rstaddr2_i,
	input  wire  [multipu_pkg::ARCHBITSZ-1:0]        id_i,
	output multipu_pkg::pu_boot_s                    boot_o [multipu_pkg::PUCOUNT],
	output logic [multipu_pkg::PUCOUNT-1:0]          intrdy_o
);

	// one flag per unit, set once and held until reset
	logic [multipu_pkg::PUCOUNT-1:0] awake_q;

	// unit 0 never takes a wake request
	assign intrdy_o = {~awake_q[multipu_pkg::PUCOUNT-1:1], 1'b0};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			awake_q <= '0;
		end else begin
			// a pulse only counts while the unit still waits
			awake_q <= awake_q | (intrqst_i & intrdy_o);
			// unit 0 runs from the first cycle out of reset
			awake_q[0] <= 1'b1;
		end
	end

	always_comb begin
		for (int k = 0; k < multipu_pkg::PUCOUNT; k++) begin
			boot_o[k].run = awake_q[k];
			// unit 0 boots at rstaddr, the rest at rstaddr2
			boot_o[k].startaddr = (k == 0) ? rstaddr_i : rstaddr2_i;
			// id is id_i plus the unit index, low bits kept
			boot_o[k].id = id_i[multipu_pkg::XADDRBITSZ-1:0] + k[multipu_pkg::XADDRBITSZ-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== design/multipu_pkg.sv ====
////////////////////
// multipu cluster package
// widths, cluster size, pi1 op codes, unit opcodes,
// the instruction word views and the request/boot structs
////////////////////
`default_nettype none

package multipu_pkg;

	// data word and halfword address widths
	localparam int ARCHBITSZ  = 16;
	// byte lane bit dropped from the address
	localparam int XADDRBITSZ = ARCHBITSZ - 1;
	localparam int SELBITSZ   = ARCHBITSZ / 8;

	// cluster size and the index width that goes with it
	localparam int PUCOUNT    = 4;
	localparam int PUIDXBITSZ = $clog2(PUCOUNT);

	// operand field of an instruction word
	localparam int IMMBITSZ   = 12;

	// pi1 bus ops
	localparam logic [1:0] PINOOP = 2'b00;
	localparam logic [1:0] PIWROP = 2'b01;
	localparam logic [1:0] PIRDOP = 2'b10;
	localparam logic [1:0] PIRWOP = 2'b11;

	typedef enum logic [3:0] {
		OP_LDI  = 4'h0,
		OP_LID  = 4'h1,
		OP_LD   = 4'h2,
		OP_ADD  = 4'h3,
		OP_ADDI = 4'h4,
		OP_ST   = 4'h5,
		OP_STX  = 4'h6,
		OP_HALT = 4'h7
	} pu_opcode_e;

	// immediate view, zero-extended value
	typedef struct packed {
		pu_opcode_e            op;
		logic [IMMBITSZ-1:0]   imm;
	} pu_imm_s;

	// memory view, halfword offset in the unit's data window
	typedef struct packed {
		pu_opcode_e            op;
		logic [IMMBITSZ-1:0]   addr;
	} pu_mem_s;

	typedef union packed {
		pu_imm_s i;
		pu_mem_s m;
	} pu_instr_u;

	// one master's pi1 request, 35 bits
	typedef struct packed {
		logic [1:0]            op;
		logic [XADDRBITSZ-1:0] addr;
		logic [ARCHBITSZ-1:0]  data;
		logic [SELBITSZ-1:0]   sel;
	} pi1_req_s;

	// wake controller to one unit, 31 bits
	typedef struct packed {
		logic                  run;
		logic [XADDRBITSZ-1:0] startaddr;
		logic [XADDRBITSZ-1:0] id;
	} pu_boot_s;

endpackage

`default_nettype wire
